/* src/rsPkg.sv */
package rsPkg;

    // station geometry
    localparam int RsDepth        = 16;
    localparam int SelectWindow   = 8;   // entries examined from the head
    localparam int NumWakeupPorts = 4;   // alu, mul, div, load
    localparam int PhysTagWidth   = 8;

    typedef logic [PhysTagWidth-1:0]     physTag;
    typedef logic [$clog2(RsDepth)-1:0]  rsIndex;
    typedef logic [31:0]                 instNum;
    typedef logic [3:0]                  aluOp;
    typedef logic [2:0]                  funct3Field;
    typedef logic [31:0]                 immValue;

    // fields kept per entry and handed to the alu on issue
    typedef struct packed {
        instNum     instNumber;
        physTag     destTag;
        logic       memToReg;
        logic       memRead;
        logic       memWrite;
        aluOp       op;
        logic       aluSrc2;
        funct3Field funct3;
        immValue    immediate;
        physTag     src1Tag;
        physTag     src2Tag;
    } rsPayload;

    // what the rename stage sends in
    typedef struct packed {
        rsPayload payload;
        logic     src1Ready;
        logic     src2Ready;
    } rsDispatch;

    // one result bus, single cycle pulse
    typedef struct packed {
        logic   valid;
        physTag tag;
    } wakeupBroadcast;

endpackage

/* src/wakeupMatch.sv */
`timescale 1ns/10ps

module wakeupMatch (
    input  rsPkg::physTag         tag,
    input  rsPkg::wakeupBroadcast wakeup [rsPkg::NumWakeupPorts],
    output logic                  hit
);

    import rsPkg::*;

    logic [NumWakeupPorts-1:0] portHit;

    // a bus only counts while its valid is up
    always_comb begin
        for (int p = 0; p < NumWakeupPorts; p++) begin
            portHit[p] = wakeup[p].valid && (wakeup[p].tag == tag);
        end
    end

    assign hit = |portHit;

endmodule

/* src/rsEntryArray.sv */
`timescale 1ns/10ps

module rsEntryArray (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dispatchValid,
    input  rsPkg::rsDispatch       dispatch,
    input  logic                   dispatchHit1,
    input  logic                   dispatchHit2,
    input  rsPkg::wakeupBroadcast  wakeup [rsPkg::NumWakeupPorts],
    input  logic                   issueStrobe,
    input  rsPkg::rsIndex          issueIndex,
    output logic                   dispatchReady,
    output rsPkg::rsIndex          head,
    output logic [rsPkg::RsDepth-1:0] entryReady,
    output rsPkg::rsPayload        payloads [rsPkg::RsDepth]
);

    import rsPkg::*;

    rsIndex tail;

    logic [RsDepth-1:0] allocated;  // between head and tail
    logic [RsDepth-1:0] issued;
    logic [RsDepth-1:0] src1Rdy;
    logic [RsDepth-1:0] src2Rdy;
    logic [RsDepth-1:0] hit1;
    logic [RsDepth-1:0] hit2;

    logic full;
    logic accept;
    logic advance;

    // slots fill contiguously, so the tail slot is only busy when every slot is
    assign full          = allocated[tail];
    assign dispatchReady = !full;
    assign accept        = dispatchValid && dispatchReady;

    // reclaim capacity only from the head, in order
    assign advance = allocated[head] && issued[head];

    assign entryReady = allocated & src1Rdy & src2Rdy & ~issued;

    for (genvar e = 0; e < RsDepth; e++) begin : gWake
        wakeupMatch i_src1Match (
            .tag    (payloads[e].src1Tag),
            .wakeup (wakeup),
            .hit    (hit1[e])
        );

        wakeupMatch i_src2Match (
            .tag    (payloads[e].src2Tag),
            .wakeup (wakeup),
            .hit    (hit2[e])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            allocated <= '0;
            issued    <= '0;
            src1Rdy   <= '0;
            src2Rdy   <= '0;
        end else begin
            if (accept) begin
                tail <= tail + rsIndex'(1);
            end
            if (advance) begin
                head <= head + rsIndex'(1);
            end

            // tail, head and issue index never name the same slot in one cycle
            for (int e = 0; e < RsDepth; e++) begin
                if (accept && tail == rsIndex'(e)) begin
                    allocated[e] <= 1'b1;
                    issued[e]    <= 1'b0;
                    src1Rdy[e]   <= dispatch.src1Ready || dispatchHit1; // same-cycle bypass
                    src2Rdy[e]   <= dispatch.src2Ready || dispatchHit2;
                end else if (issueStrobe && issueIndex == rsIndex'(e)) begin
                    issued[e]  <= 1'b1;
                    src1Rdy[e] <= 1'b0;
                    src2Rdy[e] <= 1'b0;
                end else begin
                    if (advance && head == rsIndex'(e)) begin
                        allocated[e] <= 1'b0;
                    end
                    if (allocated[e] && !issued[e]) begin
                        if (hit1[e]) begin
                            src1Rdy[e] <= 1'b1;
                        end
                        if (hit2[e]) begin
                            src2Rdy[e] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // entry fields, written at the tail
    always_ff @(posedge clk) begin
        if (accept) begin
            payloads[tail] <= dispatch.payload;
        end
    end

endmodule

/* src/issueSelect.sv */
`timescale 1ns/10ps

module issueSelect (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [rsPkg::RsDepth-1:0] entryReady,
    input  rsPkg::rsIndex             head,
    input  rsPkg::rsPayload           payloads [rsPkg::RsDepth],
    input  logic                      issueReady,
    output logic                      issueStrobe,
    output rsPkg::rsIndex             issueIndex,
    output logic                      issueValid,
    output rsPkg::rsPayload           issue
);

    import rsPkg::*;

    logic   found;
    rsIndex pick;
    logic   loadEnable;

    // first ready slot counting from the head, oldest wins
    always_comb begin
        found = 1'b0;
        pick  = head;
        for (int w = 0; w < SelectWindow; w++) begin
            if (!found && entryReady[head + rsIndex'(w)]) begin
                found = 1'b1;
                pick  = head + rsIndex'(w);
            end
        end
    end

    assign loadEnable  = !issueValid || issueReady;  // empty or being taken
    assign issueStrobe = loadEnable && found;
    assign issueIndex  = pick;

    always_ff @(posedge clk) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else if (loadEnable) begin
            issueValid <= found;
        end
    end

    // held until the alu takes it
    always_ff @(posedge clk) begin
        if (issueStrobe) begin
            issue <= payloads[pick];
        end
    end

endmodule

/* src/reservationStation.sv */
`timescale 1ns/10ps

module reservationStation (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatchValid,
    input  rsPkg::rsDispatch      dispatch,
    output logic                  dispatchReady,
    input  rsPkg::wakeupBroadcast wakeup [rsPkg::NumWakeupPorts],
    output logic                  issueValid,
    output rsPkg::rsPayload       issue,
    input  logic                  issueReady
);

    import rsPkg::*;

    logic               dispatchHit1;
    logic               dispatchHit2;
    logic               issueStrobe;
    rsIndex             issueIndex;
    rsIndex             head;
    logic [RsDepth-1:0] entryReady;
    rsPayload           payloads [RsDepth];

    // catch results that land in the dispatch cycle
    wakeupMatch i_dispatchMatch1 (
        .tag    (dispatch.payload.src1Tag),
        .wakeup (wakeup),
        .hit    (dispatchHit1)
    );

    wakeupMatch i_dispatchMatch2 (
        .tag    (dispatch.payload.src2Tag),
        .wakeup (wakeup),
        .hit    (dispatchHit2)
    );

    rsEntryArray i_rsEntryArray (
        .clk           (clk),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .dispatchHit1  (dispatchHit1),
        .dispatchHit2  (dispatchHit2),
        .wakeup        (wakeup),
        .issueStrobe   (issueStrobe),
        .issueIndex    (issueIndex),
        .dispatchReady (dispatchReady),
        .head          (head),
        .entryReady    (entryReady),
        .payloads      (payloads)
    );

    issueSelect i_issueSelect (
        .clk         (clk),
        .reset       (reset),
        .entryReady  (entryReady),
        .head        (head),
        .payloads    (payloads),
        .issueReady  (issueReady),
        .issueStrobe (issueStrobe),
        .issueIndex  (issueIndex),
        .issueValid  (issueValid),
        .issue       (issue)
    );

endmodule

/* tb/rsHandshake_checker.sv */
`timescale 1ns/10ps

module rsHandshake_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      dispatchValid,
    input logic                      dispatchReady,
    input rsPkg::rsIndex             tail,
    input logic [rsPkg::RsDepth-1:0] allocated,
    input logic                      issueValid,
    input logic                      issueReady,
    input rsPkg::rsPayload           issue
);

    // a stalled packet stays put until the alu takes it
    a_issueHeld: assert property (
        @(posedge clk) disable iff (reset)
        issueValid && !issueReady |=> issueValid && $stable(issue)
    ) else $error("issue register changed while issueReady was low");

    // refusal means every slot is busy and the tail stays put
    a_noAcceptWhenFull: assert property (
        @(posedge clk) disable iff (reset)
        dispatchValid && !dispatchReady |=> $stable(tail) && (&$past(allocated))
    ) else $error("dispatch refused with a free slot or accepted while dispatchReady was low");

    a_resetState: assert property (
        @(posedge clk)
        $fell(reset) |-> !issueValid && dispatchReady
    ) else $error("station not idle in the first cycle after reset");

endmodule

bind reservationStation rsHandshake_checker i_rsHandshakeChecker (
    .clk           (clk),
    .reset         (reset),
    .dispatchValid (dispatchValid),
    .dispatchReady (dispatchReady),
    .tail          (i_rsEntryArray.tail),
    .allocated     (i_rsEntryArray.allocated),
    .issueValid    (issueValid),
    .issueReady    (issueReady),
    .issue         (issue)
);

/* tb/tbReservationStation.sv */
`timescale 1ns/10ps

module tbReservationStation;

    import rsPkg::*;

    localparam int TagRange       = 16;  // few tags, so wakeups hit often
    localparam int RandomCycles   = 400;
    localparam int OrderedCycles  = 60;
    localparam int DrainLimit     = 120;
    localparam int StimulusCycles = RandomCycles + OrderedCycles
                                    + 4 * (DrainLimit + RsDepth + 3) + RsDepth + 60;
    localparam int WatchdogNs     = StimulusCycles * 40 + 2000;

    logic           clk;
    logic           reset;
    logic           dispatchValid;
    rsDispatch      dispatch;
    logic           dispatchReady;
    wakeupBroadcast wakeup [NumWakeupPorts];
    logic           issueValid;
    rsPayload       issue;
    logic           issueReady;

    integer    seed;
    int        errorCount;
    int        testCount;
    int        acceptCount;
    int        issueCount;
    int        nextInst;
    logic      inOrder;     // issue must follow dispatch order
    logic      stalled;     // packet held at the last edge
    rsPayload  heldIssue;
    rsDispatch model [$];   // outstanding entries, oldest first

    reservationStation i_reservationStation (
        .clk           (clk),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .dispatchReady (dispatchReady),
        .wakeup        (wakeup),
        .issueValid    (issueValid),
        .issue         (issue),
        .issueReady    (issueReady)
    );

    always #20 clk = ~clk;

    initial begin
        #(WatchdogNs);
        $display("watchdog expired after %0d ns, the run did not complete", WatchdogNs);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic broadcastHit(physTag tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < NumWakeupPorts; p++) begin
            if (wakeup[p].valid && wakeup[p].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // reference model, updated from the values that sit on the pins at each edge
    always @(posedge clk) begin
        int        idx;
        rsDispatch entry;
        if (!reset) begin
            if (stalled) begin
                assert (issueValid && issue == heldIssue) else begin
                    $display("Mismatch at %0t: issue = %h, expected %h", $time, issue, heldIssue);
                    errorCount++;
                end
            end
            stalled   = issueValid && !issueReady;
            heldIssue = issue;
            if (issueValid && issueReady) begin
                idx = -1;
                foreach (model[i]) begin
                    if (model[i].payload.instNumber == issue.instNumber) begin
                        idx = i;
                    end
                end
                assert (idx >= 0) else begin
                    $display("instruction %0d issued at %0t but is not outstanding",
                             issue.instNumber, $time);
                    errorCount++;
                end
                if (idx >= 0) begin
                    assert (issue == model[idx].payload) else begin
                        $display("Mismatch at %0t: issue = %h, expected %h",
                                 $time, issue, model[idx].payload);
                        errorCount++;
                    end
                    assert (model[idx].src1Ready && model[idx].src2Ready) else begin
                        $display("instruction %0d issued at %0t before both operands were woken",
                                 issue.instNumber, $time);
                        errorCount++;
                    end
                    assert (!inOrder || idx == 0) else begin
                        $display("Mismatch at %0t: issue.instNumber = %0d, expected %0d",
                                 $time, issue.instNumber, model[0].payload.instNumber);
                        errorCount++;
                    end
                    model.delete(idx);
                    issueCount++;
                end
            end
            foreach (model[i]) begin
                model[i].src1Ready = model[i].src1Ready || broadcastHit(model[i].payload.src1Tag);
                model[i].src2Ready = model[i].src2Ready || broadcastHit(model[i].payload.src2Tag);
            end
            if (dispatchValid && dispatchReady) begin
                entry           = dispatch;
                entry.src1Ready = dispatch.src1Ready || broadcastHit(dispatch.payload.src1Tag);
                entry.src2Ready = dispatch.src2Ready || broadcastHit(dispatch.payload.src2Tag);
                model.push_back(entry);
                acceptCount++;
            end
        end
    end

    task automatic pickDispatch(logic allReady);
        dispatch.payload.instNumber = instNum'(nextInst);
        dispatch.payload.destTag    = physTag'($random(seed));
        dispatch.payload.memToReg   = 1'($random(seed));
        dispatch.payload.memRead    = 1'($random(seed));
        dispatch.payload.memWrite   = 1'($random(seed));
        dispatch.payload.op         = aluOp'($random(seed));
        dispatch.payload.aluSrc2    = 1'($random(seed));
        dispatch.payload.funct3     = funct3Field'($random(seed));
        dispatch.payload.immediate  = immValue'($random(seed));
        dispatch.payload.src1Tag    = physTag'($unsigned($random(seed)) % TagRange);
        dispatch.payload.src2Tag    = physTag'($unsigned($random(seed)) % TagRange);
        dispatch.src1Ready          = allReady || 1'($random(seed));
        dispatch.src2Ready          = allReady || 1'($random(seed));
        nextInst++;
    endtask

    task automatic setWakeups(logic active);
        for (int p = 0; p < NumWakeupPorts; p++) begin
            wakeup[p].valid = active && (($unsigned($random(seed)) % 4) == 0);
            wakeup[p].tag   = physTag'($unsigned($random(seed)) % TagRange);
        end
    endtask

    // broadcast every tag until the model runs dry, then let the head catch up
    task automatic drainStation();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            dispatchValid = 1'b0;
            issueReady    = 1'b1;
            for (int p = 0; p < NumWakeupPorts; p++) begin
                wakeup[p].valid = 1'b1;
                wakeup[p].tag   = physTag'((cycles * NumWakeupPorts + p) % TagRange);
            end
            cycles++;
        end while ((model.size() != 0 || issueValid) && cycles < DrainLimit);
        assert (model.size() == 0 && !issueValid) else begin
            $display("%0d entries still outstanding after %0d drain cycles",
                     model.size(), DrainLimit);
            errorCount++;
        end
        repeat (RsDepth + 2) begin
            @(negedge clk);
            setWakeups(1'b0);
        end
    endtask

    task automatic trafficBurst(int cycles, logic allReady);
        repeat (cycles) begin
            @(negedge clk);
            pickDispatch(allReady);
            dispatchValid = ($unsigned($random(seed)) % 4) != 0;
            issueReady    = allReady || (($unsigned($random(seed)) % 3) != 0);
            setWakeups(1'b1);
        end
        drainStation();
    endtask

    task automatic wakeupGating();
        int target;
        int waited;
        target = issueCount + 1;
        @(negedge clk);
        pickDispatch(1'b0);
        dispatch.payload.src1Tag = physTag'(5);
        dispatch.src1Ready       = 1'b0;
        dispatch.src2Ready       = 1'b1;
        dispatchValid            = 1'b1;
        issueReady               = 1'b1;
        for (int p = 0; p < NumWakeupPorts; p++) begin
            wakeup[p].valid = 1'b0;   // right tag, valid low
            wakeup[p].tag   = physTag'(5);
        end
        repeat (8) begin
            @(negedge clk);
            dispatchValid = 1'b0;
            assert (!issueValid) else begin
                $display("entry issued at %0t although its tag was only seen with valid low",
                         $time);
                errorCount++;
            end
        end
        wakeup[2].valid = 1'b1;
        @(negedge clk);
        setWakeups(1'b0);
        waited = 0;
        while (issueCount < target && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        assert (issueCount == target) else begin
            $display("woken entry did not issue within 10 cycles");
            errorCount++;
        end
        drainStation();
    endtask

    task automatic backPressure();
        int startAccepts;
        int occupied;
        startAccepts = acceptCount;
        repeat (RsDepth + 5) begin
            @(negedge clk);
            occupied = acceptCount - startAccepts;
            assert (dispatchReady == (occupied < RsDepth)) else begin
                $display("Mismatch at %0t: dispatchReady = %b, expected %b",
                         $time, dispatchReady, occupied < RsDepth);
                errorCount++;
            end
            pickDispatch(1'b0);
            dispatch.src1Ready = 1'b0;
            dispatch.src2Ready = 1'b0;
            dispatchValid      = 1'b1;
            issueReady         = 1'b0;
            setWakeups(1'b0);
        end
        drainStation();
    endtask

    task automatic finishTest(string name, int startErrors);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errorCount - startErrors);
    endtask

    initial begin
        int startErrors;
        seed          = 29;
        errorCount    = 0;
        testCount     = 0;
        acceptCount   = 0;
        issueCount    = 0;
        nextInst      = 0;
        inOrder       = 1'b0;
        stalled       = 1'b0;
        heldIssue     = '0;
        clk           = 1'b0;
        reset         = 1'b1;
        dispatchValid = 1'b0;
        dispatch      = '0;
        issueReady    = 1'b0;
        for (int p = 0; p < NumWakeupPorts; p++) begin
            wakeup[p] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        startErrors = errorCount;
        @(negedge clk);
        assert (!issueValid && dispatchReady) else begin
            $display("Mismatch at %0t: issueValid = %b dispatchReady = %b, expected 0 and 1",
                     $time, issueValid, dispatchReady);
            errorCount++;
        end
        finishTest("reset state", startErrors);

        startErrors = errorCount;
        trafficBurst(RandomCycles, 1'b0);
        finishTest("random traffic", startErrors);

        startErrors = errorCount;
        inOrder     = 1'b1;
        trafficBurst(OrderedCycles, 1'b1);
        inOrder     = 1'b0;
        finishTest("dispatch order", startErrors);

        startErrors = errorCount;
        wakeupGating();
        finishTest("wakeup valid gating", startErrors);

        startErrors = errorCount;
        backPressure();
        finishTest("back-pressure and full", startErrors);

        $display("%0d tests, %0d accepted, %0d issued, %0d errors",
                 testCount, acceptCount, issueCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/rsPkg.sv
src/wakeupMatch.sv
src/rsEntryArray.sv
src/issueSelect.sv
src/reservationStation.sv
tb/rsHandshake_checker.sv
tb/tbReservationStation.sv

/* Makefile */
TOP = tbReservationStation

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
